// File: src/dsp_pkg.sv
// shared widths, depths and shot timing for the readout DSP block, imported by every RTL file
package dsp_pkg;

	// one signed ADC sample
	localparam int adc_width = 16;

	// accumulated result per shot, wide enough for many samples
	localparam int acc_width = 32;

	// result buffer geometry
	localparam int acc_depth = 8;
	localparam int acc_addr_width = 3;

	// shot count and requested number of shots
	localparam int nshot_width = 32;

	// integration window per shot, in dspif cycles
	localparam int gate_len = 16;

	// gate window counter, sized from the window length
	localparam int gate_cnt_width = $clog2(gate_len);

	// excited-shot counter
	localparam int cnt_width = 16;

endpackage

// File: src/shot_sequencer.sv
// multi-shot experiment FSM; opens one integration gate per shot and flags the end of the run
`timescale 1ns/1ps

module shot_sequencer (
	input  logic                            dspif,
	input  logic                            rst_n,
	input  logic                            stb_start,
	input  logic [dsp_pkg::nshot_width-1:0] nshot,
	input  logic                            busy,
	output logic                            gate,
	output logic [dsp_pkg::nshot_width-1:0] shot_cnt,
	output logic                            last_shot_done
);
	import dsp_pkg::*;

	typedef enum logic [2:0] {
		st_idle     = 3'b000,
		st_start    = 3'b001,
		st_procrun  = 3'b011,
		st_elembusy = 3'b010,
		st_moreshot = 3'b110,
		st_shotadd  = 3'b111,
		st_done     = 3'b101
	} state_t;

	state_t state;
	state_t next_state;

	// shot count latched at idle
	logic [nshot_width-1:0] nshot_r;
	// index of the shot in progress
	logic [nshot_width-1:0] run_cnt;
	logic [nshot_width-1:0] next_cnt;
	// precomputed, settles long before moreshot
	logic more_shot;
	logic [gate_cnt_width-1:0] gate_cnt;
	logic gate_last;

	assign gate_last = (gate_cnt == gate_cnt_width'(gate_len - 1));

	always_comb begin
		next_state = state;
		case (state)
			st_idle:     if (stb_start) next_state = st_start;
			st_start:    next_state = st_procrun;
			// window length set by the gate counter
			st_procrun:  if (gate_last) next_state = st_elembusy;
			// hold until the integrator has delivered its result
			st_elembusy: if (!busy) next_state = st_moreshot;
			st_moreshot: next_state = more_shot ? st_shotadd : st_done;
			st_shotadd:  next_state = st_start;
			st_done:     next_state = st_idle;
			default:     next_state = st_idle;
		endcase
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			gate <= 1'b0;
			gate_cnt <= '0;
			nshot_r <= '0;
			run_cnt <= '0;
			next_cnt <= '0;
			more_shot <= 1'b0;
			shot_cnt <= '0;
			last_shot_done <= 1'b0;
		end else begin
			state <= next_state;
			// registered gate lines up with the procrun cycles
			gate <= (next_state == st_procrun);
			if (state == st_procrun)
				gate_cnt <= gate_cnt + 1'b1;
			else
				gate_cnt <= '0;
			if (state == st_idle) begin
				nshot_r <= nshot;
				run_cnt <= '0;
			end else if (state == st_shotadd) begin
				run_cnt <= next_cnt;
			end
			next_cnt <= run_cnt + 1'b1;
			// nshot of zero gives a single shot
			more_shot <= (next_cnt < nshot_r);
			// report the shot just finished
			if (state == st_moreshot)
				shot_cnt <= run_cnt;
			if (stb_start && state == st_idle)
				last_shot_done <= 1'b0;
			else if (state == st_done)
				last_shot_done <= 1'b1;
		end
	end

	// gate window never overruns its length
	assert property (@(posedge dspif) disable iff (!rst_n)
		gate [*gate_len] |=> !gate);

endmodule

// File: src/readout_integrator.sv
// gated accumulator; sums signed ADC samples over each gate window into one result per shot
`timescale 1ns/1ps

module readout_integrator (
	input  logic                                 dspif,
	input  logic                                 rst_n,
	input  logic                                 gate,
	input  logic signed [dsp_pkg::adc_width-1:0] adc,
	output logic                                 busy,
	output logic                                 acc_valid,
	output logic signed [dsp_pkg::acc_width-1:0] acc_data
);
	import dsp_pkg::*;

	logic gate_d;
	logic gate_rise;
	logic gate_fall;
	// sample widened to the accumulator
	logic signed [acc_width-1:0] adc_ext;
	logic signed [acc_width-1:0] sum;

	assign gate_rise = gate & ~gate_d;
	assign gate_fall = ~gate & gate_d;
	assign adc_ext = acc_width'(adc);

	// high from gate open until the result strobe
	assign busy = gate | gate_d;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			gate_d <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			gate_d <= gate;
			// one strobe per window, right after it closes
			acc_valid <= gate_fall;
		end
	end

	// first sample restarts the sum
	always_ff @(posedge dspif) begin
		if (gate_rise)
			sum <= adc_ext;
		else if (gate)
			sum <= sum + adc_ext;
	end

	// sum holds still once the gate is low
	assign acc_data = sum;

	// strobe comes only from a closed window
	assert property (@(posedge dspif) disable iff (!rst_n)
		acc_valid |-> $past(gate, 2) && !$past(gate));

endmodule

// File: src/acc_buffer.sv
// shot result memory with a locking write pointer, a host read port and a forwarded copy per write
`timescale 1ns/1ps

module acc_buffer (
	input  logic                                 dspif,
	input  logic                                 rst_n,
	input  logic                                 resetacc,
	input  logic                                 acc_valid,
	input  logic signed [dsp_pkg::acc_width-1:0] acc_data,
	input  logic [dsp_pkg::acc_addr_width-1:0]   rd_addr,
	output logic signed [dsp_pkg::acc_width-1:0] rd_data,
	output logic [dsp_pkg::acc_addr_width-1:0]   wr_addr,
	output logic                                 stored_valid,
	output logic signed [dsp_pkg::acc_width-1:0] stored_data
);
	import dsp_pkg::*;

	logic signed [acc_width-1:0] mem [0:acc_depth-1];
	// pointer parked on the last entry
	logic lock_last;

	assign lock_last = (wr_addr == acc_addr_width'(acc_depth - 1));

	// write port and host read port
	always_ff @(posedge dspif) begin
		if (acc_valid)
			mem[wr_addr] <= acc_data;
		rd_data <= mem[rd_addr];
	end

	// forwarded copy of the word just written
	always_ff @(posedge dspif) begin
		if (acc_valid)
			stored_data <= acc_data;
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			stored_valid <= 1'b0;
			wr_addr <= '0;
		end else begin
			stored_valid <= acc_valid;
			// advance one edge after the write, stop at the end
			if (resetacc)
				wr_addr <= '0;
			else if (stored_valid && !lock_last)
				wr_addr <= wr_addr + 1'b1;
		end
	end

	// pointer frozen while clear is held
	assert property (@(posedge dspif) disable iff (!rst_n)
		resetacc && $past(resetacc) |=> $stable(wr_addr));

endmodule

// File: src/state_discriminator.sv
// threshold state decision per stored result, with a saturating count of excited shots
`timescale 1ns/1ps

module state_discriminator (
	input  logic                                 dspif,
	input  logic                                 rst_n,
	input  logic                                 resetacc,
	input  logic                                 stored_valid,
	input  logic signed [dsp_pkg::acc_width-1:0] stored_data,
	input  logic signed [dsp_pkg::acc_width-1:0] threshold,
	output logic                                 meas,
	output logic                                 meas_valid,
	output logic [dsp_pkg::cnt_width-1:0]        excited_cnt
);
	import dsp_pkg::*;

	// signed compare, at threshold counts as excited
	logic excited;
	logic cnt_full;

	assign excited = (stored_data >= threshold);
	assign cnt_full = &excited_cnt;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			meas <= 1'b0;
			meas_valid <= 1'b0;
			excited_cnt <= '0;
		end else begin
			meas_valid <= stored_valid;
			if (stored_valid)
				meas <= excited;
			// clear wins over a new count
			if (resetacc)
				excited_cnt <= '0;
			else if (stored_valid && excited && !cnt_full)
				excited_cnt <= excited_cnt + 1'b1;
		end
	end

endmodule

// File: src/dsp_top.sv
// readout DSP top level; connects sequencer, integrator, result buffer and discriminator
`timescale 1ns/1ps

module dsp_top (
	input  logic                                  dspif,
	input  logic                                  rst_n,
	input  logic [dsp_pkg::nshot_width-1:0]       nshot,
	input  logic                                  stb_start,
	input  logic                                  resetacc,
	input  logic [dsp_pkg::acc_addr_width-1:0]    rd_addr,
	input  logic signed [dsp_pkg::acc_width-1:0]  threshold,
	input  logic signed [dsp_pkg::adc_width-1:0]  adc,
	output logic                                  gate,
	output logic [dsp_pkg::nshot_width-1:0]       shot_cnt,
	output logic                                  last_shot_done,
	output logic                                  acc_valid,
	output logic signed [dsp_pkg::acc_width-1:0]  acc_data,
	output logic [dsp_pkg::acc_addr_width-1:0]    wr_addr,
	output logic signed [dsp_pkg::acc_width-1:0]  rd_data,
	output logic                                  meas,
	output logic                                  meas_valid,
	output logic [dsp_pkg::cnt_width-1:0]         excited_cnt
);
	import dsp_pkg::*;

	// integrator back to sequencer
	logic busy;
	// buffer to discriminator
	logic stored_valid;
	logic signed [acc_width-1:0] stored_data;

	shot_sequencer shot_sequencer_inst (
		.dspif          (dspif),
		.rst_n          (rst_n),
		.stb_start      (stb_start),
		.nshot          (nshot),
		.busy           (busy),
		.gate           (gate),
		.shot_cnt       (shot_cnt),
		.last_shot_done (last_shot_done)
	);

	readout_integrator readout_integrator_inst (
		.dspif     (dspif),
		.rst_n     (rst_n),
		.gate      (gate),
		.adc       (adc),
		.busy      (busy),
		.acc_valid (acc_valid),
		.acc_data  (acc_data)
	);

	acc_buffer acc_buffer_inst (
		.dspif        (dspif),
		.rst_n        (rst_n),
		.resetacc     (resetacc),
		.acc_valid    (acc_valid),
		.acc_data     (acc_data),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.wr_addr      (wr_addr),
		.stored_valid (stored_valid),
		.stored_data  (stored_data)
	);

	state_discriminator state_discriminator_inst (
		.dspif        (dspif),
		.rst_n        (rst_n),
		.resetacc     (resetacc),
		.stored_valid (stored_valid),
		.stored_data  (stored_data),
		.threshold    (threshold),
		.meas         (meas),
		.meas_valid   (meas_valid),
		.excited_cnt  (excited_cnt)
	);

endmodule

// File: verif/tb_clock.sv
// testbench clock and reset source for dsp_top; 4 ns dspif period, rst_n low for three cycles
`timescale 1ns/1ps

module tb_clock #(
	parameter real half_period = 2.0,
	parameter int reset_cycles = 3
) (
	output logic dspif,
	output logic rst_n
);
	initial begin
		dspif = 1'b0;
		forever #(half_period) dspif = ~dspif;
	end

	// release between edges, away from the flops' sampling point
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge dspif);
		@(negedge dspif);
		rst_n = 1'b1;
	end

endmodule

// File: verif/tb_dsp.sv
// testbench for dsp_top; runs multi-shot experiments and checks them with assertions
`timescale 1ns/1ps

module tb_dsp;
	import dsp_pkg::*;

	localparam int wait_limit = 100;

	logic dspif;
	logic rst_n;
	logic [nshot_width-1:0] nshot;
	logic stb_start;
	logic resetacc;
	logic [acc_addr_width-1:0] rd_addr;
	logic signed [acc_width-1:0] threshold;
	logic signed [adc_width-1:0] adc;
	logic gate;
	logic [nshot_width-1:0] shot_cnt;
	logic last_shot_done;
	logic acc_valid;
	logic signed [acc_width-1:0] acc_data;
	logic [acc_addr_width-1:0] wr_addr;
	logic signed [acc_width-1:0] rd_data;
	logic meas;
	logic meas_valid;
	logic [cnt_width-1:0] excited_cnt;

	integer seed = 32'h1e7f;
	// samples and model sums of the current run, one per shot
	logic signed [adc_width-1:0] sample_q [$];
	logic signed [acc_width-1:0] sum_q [$];
	int gate_windows = 0;
	int done_rises = 0;
	logic gate_prev = 1'b0;
	logic done_prev = 1'b0;

	tb_clock tb_clock_inst (.dspif(dspif), .rst_n(rst_n));

	dsp_top dsp_top_inst (.*);

	// edge counters, updated like any flop on the DUT's clock
	always @(posedge dspif) begin
		gate_prev <= gate;
		done_prev <= last_shot_done;
		if (gate && !gate_prev)
			gate_windows <= gate_windows + 1;
		if (last_shot_done && !done_prev)
			done_rises <= done_rises + 1;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] want);
		assert (got == want)
		else stop_with_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, want));
	endtask

	// every window lasts exactly gate_len cycles
	assert property (@(posedge dspif) disable iff (!rst_n)
		$rose(gate) |-> gate [*gate_len] ##1 !gate)
	else stop_with_error("gate window length differs from gate_len");

	// decision two cycles after the result
	assert property (@(posedge dspif) disable iff (!rst_n) acc_valid |-> ##2 meas_valid)
	else stop_with_error($sformatf("FAIL meas_valid got 0x%0h expected 0x1", meas_valid));
	assert property (@(posedge dspif) disable iff (!rst_n) meas_valid |-> $past(acc_valid, 2))
	else stop_with_error("meas_valid pulsed without a shot result");

	// a new start drops the done flag
	assert property (@(posedge dspif) disable iff (!rst_n)
		stb_start && last_shot_done |=> !last_shot_done)
	else stop_with_error("last_shot_done stayed high after stb_start");

	task automatic wait_acc_valid();
		int n;
		n = 0;
		@(negedge dspif);
		while (!acc_valid && n < wait_limit) begin
			@(negedge dspif);
			n++;
		end
		if (!acc_valid)
			stop_with_error("timeout waiting for acc_valid");
	endtask

	task automatic wait_shots_done();
		int n;
		n = 0;
		while (!last_shot_done && n < wait_limit) begin
			@(negedge dspif);
			n++;
		end
		if (!last_shot_done)
			stop_with_error("timeout waiting for last_shot_done");
	endtask

	function automatic int count_excited(input logic signed [acc_width-1:0] thr);
		int n;
		n = 0;
		foreach (sum_q[k])
			if (sum_q[k] >= thr)
				n++;
		return n;
	endfunction

	task automatic make_samples(input int count);
		logic signed [adc_width-1:0] s;
		sample_q.delete();
		sum_q.delete();
		repeat (count) begin
			s = adc_width'($random(seed));
			sample_q.push_back(s);
			// sample is held over the whole window
			sum_q.push_back(acc_width'(s) * acc_width'(gate_len));
		end
	endtask

	task automatic run_shots();
		int windows_before;
		int done_before;
		windows_before = gate_windows;
		done_before = done_rises;
		nshot = nshot_width'(sum_q.size());
		adc = sample_q[0];
		stb_start = 1'b1;
		@(negedge dspif);
		stb_start = 1'b0;
		check_hex("last_shot_done", 64'(last_shot_done), 64'(0));
		// next sample goes out after each decision, ahead of the next window
		foreach (sum_q[k]) begin
			adc = sample_q[k];
			wait_acc_valid();
			check_hex("acc_data", 64'(acc_data), 64'(sum_q[k]));
			// decision lands two edges after the result strobe
			repeat (2) @(negedge dspif);
			check_hex("meas", 64'(meas), 64'(sum_q[k] >= threshold));
		end
		wait_shots_done();
		@(negedge dspif);
		check_hex("gate_windows", 64'(gate_windows - windows_before), 64'(sum_q.size()));
		check_hex("done_rises", 64'(done_rises - done_before), 64'(1));
		check_hex("shot_cnt", 64'(shot_cnt), 64'(sum_q.size() - 1));
	endtask

	task automatic read_back();
		int i;
		int last;
		logic signed [acc_width-1:0] want;
		last = sum_q.size() - 1;
		for (i = 0; i <= last && i < acc_depth; i++) begin
			rd_addr = acc_addr_width'(i);
			@(negedge dspif);
			// parked pointer keeps overwriting the last entry
			want = (i == acc_depth - 1) ? sum_q[last] : sum_q[i];
			check_hex("rd_data", 64'(rd_data), 64'(want));
		end
	endtask

	task automatic clear_results();
		resetacc = 1'b1;
		repeat (2) @(negedge dspif);
		resetacc = 1'b0;
		check_hex("wr_addr", 64'(wr_addr), 64'(0));
		check_hex("excited_cnt", 64'(excited_cnt), 64'(0));
	endtask

	initial begin
		logic signed [acc_width-1:0] ordered [$];
		int n;
		nshot = '0;
		stb_start = 1'b0;
		resetacc = 1'b0;
		rd_addr = '0;
		threshold = '0;
		adc = '0;
		n = 0;
		while (!rst_n && n < wait_limit) begin
			@(negedge dspif);
			n++;
		end
		if (!rst_n)
			stop_with_error("timeout waiting for reset release");
		@(negedge dspif);
		check_hex("gate", 64'(gate), 64'(0));
		check_hex("acc_valid", 64'(acc_valid), 64'(0));
		check_hex("meas_valid", 64'(meas_valid), 64'(0));
		check_hex("last_shot_done", 64'(last_shot_done), 64'(0));
		check_hex("wr_addr", 64'(wr_addr), 64'(0));
		check_hex("shot_cnt", 64'(shot_cnt), 64'(0));
		check_hex("excited_cnt", 64'(excited_cnt), 64'(0));

		// three shots, threshold on the median so the equal case counts as excited
		make_samples(3);
		ordered = sum_q;
		ordered.sort();
		threshold = ordered[1];
		run_shots();
		check_hex("wr_addr", 64'(wr_addr), 64'(3));
		check_hex("excited_cnt", 64'(excited_cnt), 64'(count_excited(threshold)));
		read_back();

		// ten shots drive the pointer into the last entry
		clear_results();
		make_samples(10);
		threshold = '0;
		run_shots();
		check_hex("wr_addr", 64'(wr_addr), 64'(acc_depth - 1));
		check_hex("excited_cnt", 64'(excited_cnt), 64'(count_excited(threshold)));
		read_back();
		clear_results();

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: vlog.f
src/dsp_pkg.sv
src/shot_sequencer.sv
src/readout_integrator.sv
src/acc_buffer.sv
src/state_discriminator.sv
src/dsp_top.sv
verif/tb_clock.sv
verif/tb_dsp.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_dsp
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_MSG ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
